// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic RST_X
);

    // 40 ns period
    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // reset held low over two rising edges, released on a falling edge
    initial begin
        RST_X = 1'b0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RST_X = 1'b1;
    end

endmodule

// ==== dv/tb_dual_core_bus.sv ====
`timescale 1ns/1ps
`include "dual_core_macros.svh"

module tb_dual_core_bus
    import dual_core_pkg::*;
();

    // six tests take a few hundred cycles, random traffic the most
    localparam int MAX_CYCLES = 4000;
    localparam int RAND_XFERS = 20;

    // addi x1,x0,1 / add x1,x2,x3 / wfi / lw x1,0(x0)
    localparam logic [31:0] INSN_ADDI = {12'd1, 5'd0, 3'b000, 5'd1, `OPCODE_OP_IMM};
    localparam logic [31:0] INSN_ADD  = {7'd0, 5'd3, 5'd2, 3'b000, 5'd1, `OPCODE_OP};
    localparam logic [31:0] INSN_WFI  = {`FUNCT12_WFI, 5'd0, `FUNCT3_PRIV, 5'd0, `OPCODE_SYSTEM};
    localparam logic [31:0] INSN_LW   = {12'd0, 5'd0, 3'b010, 5'd1, 7'b0000011};

    logic               CLK;
    logic               RST_X;
    logic [`ADDR_W-1:0] ir0, ir1;
    cpu_stage_e         stage0, stage1;
    logic               req0, req1;
    logic [`ADDR_W-1:0] addr0, addr1;
    logic               we0, we1;
    logic [`DATA_W-1:0] wdata0, wdata1;
    logic [`DATA_W-1:0] rdata0, rdata1;
    logic               done0, done1;
    logic               busy0, busy1;
    logic               grant;

    logic [`DATA_W-1:0] ref_words [int];
    logic [`ADDR_W-1:0] t1_addr [4] = '{32'h0, 32'h4, 32'h10, 32'h3fc};
    int   cycle = 0;
    int   err_count = 0;
    int   test_err_base = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    int   n_changes = 0;
    int   last_change = 0;
    int   last_gap = 0;
    logic last_grant = 1'b0;

    tb_clock_gen i_clk (.CLK(CLK), .RST_X(RST_X));

    dual_core_bus_top i_dut (.*);

    function automatic int word_index(input logic [`ADDR_W-1:0] a);
        return int'((a >> 2) % `MEM_WORDS);
    endfunction

    // last value written to a word, zero if it was never written
    function automatic logic [`DATA_W-1:0] ref_mem_read(input int idx);
        if (ref_words.exists(idx)) begin
            return ref_words[idx];
        end
        return '0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %0s: expected 0x%h, got 0x%h (cycle %0d)",
                     name, exp, act, cycle);
            err_count++;
        end
    endtask

    task automatic score_done(input string name, input bit granted, input logic w,
                              input logic [31:0] a, input logic [31:0] wd,
                              input logic [31:0] rd);
        if (!granted) begin
            $display("%0s: done pulsed on a core that does not hold the bus", name);
            err_count++;
        end
        if (w) begin
            ref_words[word_index(a)] = wd;
        end else begin
            check_value(name, ref_mem_read(word_index(a)), rd);
        end
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_err_base) begin
            tests_passed++;
            $display("test %0s: pass", name);
        end else begin
            tests_failed++;
            $display("test %0s: fail, %0d errors", name, err_count - test_err_base);
        end
        test_err_base = err_count;
    endtask

    // request held stable until done
    task automatic core0_transfer(input logic w, input logic [31:0] a, input logic [31:0] d);
        @(negedge CLK);
        req0   = 1'b1;
        we0    = w;
        addr0  = a;
        wdata0 = d;
        do @(negedge CLK); while (!done0);
        req0 = 1'b0;
    endtask

    task automatic core1_transfer(input logic w, input logic [31:0] a, input logic [31:0] d);
        @(negedge CLK);
        req1   = 1'b1;
        we1    = w;
        addr1  = a;
        wdata1 = d;
        do @(negedge CLK); while (!done1);
        req1 = 1'b0;
    endtask

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    // completions against the reference memory, grant change spacing
    always @(negedge CLK) begin
        if (RST_X) begin
            if (done0) begin
                score_done("rdata0", grant == 1'b0, we0, addr0, wdata0, rdata0);
            end
            if (done1) begin
                score_done("rdata1", grant == 1'b1, we1, addr1, wdata1, rdata1);
            end
            if (grant != last_grant) begin
                last_gap    = cycle - last_change;
                last_change = cycle;
                n_changes++;
            end
            last_grant = grant;
        end
    end

    initial begin
        wait (cycle >= MAX_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int base;
        void'($urandom(32'ha0f1));
        ir0 = '0;
        stage0 = S_IF;
        req0 = 1'b0;
        addr0 = '0;
        we0 = 1'b0;
        wdata0 = '0;
        ir1 = '0;
        stage1 = S_IF;
        req1 = 1'b0;
        addr1 = '0;
        we1 = 1'b0;
        wdata1 = '0;
        wait (RST_X === 1'b1);
        @(negedge CLK);

        check_value("grant", 32'd0, 32'(grant));
        check_value("busy0", 32'd0, 32'(busy0));
        check_value("busy1", 32'd1, 32'(busy1));
        for (int i = 0; i < 4; i++) core0_transfer(1'b1, t1_addr[i], $urandom);
        for (int i = 0; i < 4; i++) core0_transfer(1'b0, t1_addr[i], '0);
        // never written, reads zero
        core0_transfer(1'b0, 32'h80, '0);
        finish_test("core 0 after reset");

        // safe point on core 0, grant moves two edges later
        ir0    = INSN_ADDI;
        stage0 = S_ID;
        @(negedge CLK);
        check_value("grant", 32'd0, 32'(grant));
        check_value("busy0", 32'd1, 32'(busy0));
        check_value("busy1", 32'd1, 32'(busy1));
        @(negedge CLK);
        check_value("grant", 32'd1, 32'(grant));
        check_value("busy0", 32'd1, 32'(busy0));
        check_value("busy1", 32'd1, 32'(busy1));
        @(negedge CLK);
        ir0    = '0;
        stage0 = S_IF;
        check_value("busy1", 32'd0, 32'(busy1));
        finish_test("switch on OP-IMM in decode");

        ir1    = INSN_WFI;
        stage1 = S_FIN;
        while (grant !== 1'b0) @(negedge CLK);
        @(negedge CLK);
        ir1    = '0;
        stage1 = S_IF;
        // hold window plus switch, idle and check cycles
        check_value("grant gap", 32'(`HOLD_CYCLES + 4), 32'(last_gap));
        finish_test("switch back on WFI in finish");

        fork
            core1_transfer(1'b0, 32'h10, '0);
            begin
                repeat (8) begin
                    @(negedge CLK);
                    check_value("done1", 32'd0, 32'(done1));
                end
                ir0    = INSN_ADDI;
                stage0 = S_ID;
                while (grant !== 1'b1) @(negedge CLK);
                ir0    = '0;
                stage0 = S_IF;
            end
        join
        finish_test("held request on core 1");

        base   = n_changes;
        ir1    = INSN_LW;
        stage1 = S_ID;
        repeat (20) @(negedge CLK);
        // one cycle of OP, the check then fails
        ir1 = INSN_ADD;
        @(negedge CLK);
        ir1 = INSN_LW;
        check_value("busy1", 32'd1, 32'(busy1));
        repeat (6) @(negedge CLK);
        ir1    = '0;
        stage1 = S_IF;
        check_value("grant", 32'd1, 32'(grant));
        check_value("grant changes", 32'd0, 32'(n_changes - base));
        finish_test("no switch on load or dropped OP");

        base   = n_changes;
        ir0    = INSN_ADDI;
        stage0 = S_ID;
        ir1    = INSN_ADDI;
        stage1 = S_ID;
        fork
            begin
                for (int k = 0; k < RAND_XFERS; k++) begin
                    core0_transfer(1'($urandom % 2), ($urandom % 32) << 2, $urandom);
                end
            end
            begin
                for (int k = 0; k < RAND_XFERS; k++) begin
                    core1_transfer(1'($urandom % 2), ($urandom % 32) << 2, $urandom);
                end
            end
        join
        ir0    = '0;
        stage0 = S_IF;
        ir1    = '0;
        stage1 = S_IF;
        @(negedge CLK);
        if (n_changes - base < 2) begin
            $display("random traffic: the grant did not alternate between the cores");
            err_count++;
        end
        finish_test("random traffic");

        $display("tests passed: %0d  tests failed: %0d  check errors: %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dual-core bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dual_core_bus -Mdir "$BUILD" -o sim_tb \
    -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== sources.f ====
+incdir+verilog
verilog/dual_core_pkg.sv
verilog/core_switch_arbiter.sv
verilog/core_bus_mux.sv
verilog/apb_shared_mem.sv
verilog/dual_core_bus_top.sv
dv/tb_clock_gen.sv
dv/tb_dual_core_bus.sv

// ==== verilog/apb_shared_mem.sv ====
`timescale 1ns/1ps
`include "dual_core_macros.svh"

module apb_shared_mem (
    input  logic               CLK,
    input  logic               RST_X,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`ADDR_W-1:0] paddr,
    input  logic [`DATA_W-1:0] pwdata,
    output logic [`DATA_W-1:0] prdata,
    output logic               pready
);

    localparam int IDX_W  = $clog2(`MEM_WORDS);
    localparam int WAIT_W = $clog2(`MEM_WAIT + 2);

    // contents start at zero and survive reset
    logic [`DATA_W-1:0] mem [`MEM_WORDS] = '{default: '0};
    logic [WAIT_W-1:0]  wait_cnt;
    logic [IDX_W-1:0]   idx;
    logic               access;

    // word index from the address bits above the byte offset
    assign idx    = paddr[IDX_W+1:2];
    assign access = psel && penable;

    // ready after MEM_WAIT access cycles
    assign pready = access && (wait_cnt == WAIT_W'(`MEM_WAIT));
    assign prdata = (pready && !pwrite) ? mem[idx] : '0;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            wait_cnt <= '0;
        end else if (access && !pready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (pready && pwrite) begin
            mem[idx] <= pwdata;
        end
    end

endmodule

// ==== verilog/core_bus_mux.sv ====
`timescale 1ns/1ps
`include "dual_core_macros.svh"

module core_bus_mux
    import dual_core_pkg::*;
(
    input  logic               CLK,
    input  logic               RST_X,
    input  logic               grant,
    input  logic               switching,
    input  logic [`ADDR_W-1:0] ir0,
    input  cpu_stage_e         stage0,
    input  logic               req0,
    input  logic [`ADDR_W-1:0] addr0,
    input  logic               we0,
    input  logic [`DATA_W-1:0] wdata0,
    input  logic [`ADDR_W-1:0] ir1,
    input  cpu_stage_e         stage1,
    input  logic               req1,
    input  logic [`ADDR_W-1:0] addr1,
    input  logic               we1,
    input  logic [`DATA_W-1:0] wdata1,
    output logic [`DATA_W-1:0] rdata0,
    output logic               done0,
    output logic               busy0,
    output logic [`DATA_W-1:0] rdata1,
    output logic               done1,
    output logic               busy1,
    output logic [`ADDR_W-1:0] sel_ir,
    output cpu_stage_e         sel_stage,
    output logic               bus_idle,
    output logic               psel,
    output logic               penable,
    output logic               pwrite,
    output logic [`ADDR_W-1:0] paddr,
    output logic [`DATA_W-1:0] pwdata,
    input  logic [`DATA_W-1:0] prdata,
    input  logic               pready
);

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

    apb_state_e         apb_state;
    logic               owner;
    logic               done_q;
    logic               start;
    logic [`DATA_W-1:0] rdata_q;
    logic [`NCORES-1:0] req_v;
    logic [`NCORES-1:0] done_v;
    logic [`NCORES-1:0] busy_v;

    assign req_v = {req1, req0};

    // granted core's status goes to the arbiter
    assign sel_ir    = grant ? ir1 : ir0;
    assign sel_stage = grant ? stage1 : stage0;
    assign bus_idle  = (apb_state == APB_IDLE);

    // no new transfer during a switch or in the done cycle
    assign start = bus_idle && req_v[grant] && !switching && !done_q;

    assign psel    = (apb_state != APB_IDLE);
    assign penable = (apb_state == APB_ACCESS);

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            apb_state <= APB_IDLE;
            owner     <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (apb_state)
                APB_IDLE: begin
                    if (start) begin
                        apb_state <= APB_SETUP;
                        owner     <= grant;
                    end
                end
                APB_SETUP: begin
                    apb_state <= APB_ACCESS;
                end
                APB_ACCESS: begin
                    if (pready) begin
                        apb_state <= APB_IDLE;
                        done_q    <= 1'b1;
                    end
                end
                default: begin
                    apb_state <= APB_IDLE;
                end
            endcase
        end
    end

    // request payload, taken once per transfer
    always_ff @(posedge CLK) begin
        if (start) begin
            paddr  <= grant ? addr1 : addr0;
            pwrite <= grant ? we1 : we0;
            pwdata <= grant ? wdata1 : wdata0;
        end
        if (penable && pready) begin
            rdata_q <= prdata;
        end
    end

    // done, busy and data follow the owner of the transfer
    always_comb begin
        for (int i = 0; i < `NCORES; i++) begin
            done_v[i] = done_q && (owner == 1'(i));
            busy_v[i] = (grant != 1'(i)) || switching || (psel && (owner == 1'(i)));
        end
    end

    assign done0  = done_v[0];
    assign done1  = done_v[1];
    assign busy0  = busy_v[0];
    assign busy1  = busy_v[1];
    assign rdata0 = done_v[0] ? rdata_q : '0;
    assign rdata1 = done_v[1] ? rdata_q : '0;

    // select and enable hold until the slave completes
    a_psel_stable: assert property (@(posedge CLK) disable iff (!RST_X)
        (penable && !pready) |=> (psel && penable));

    // an open transfer belongs to the core that holds the bus
    a_owner_granted: assert property (@(posedge CLK) disable iff (!RST_X)
        psel |-> (owner == grant));

endmodule

// ==== verilog/core_switch_arbiter.sv ====
`timescale 1ns/1ps
`include "dual_core_macros.svh"

module core_switch_arbiter
    import dual_core_pkg::*;
(
    input  logic               CLK,
    input  logic               RST_X,
    input  logic [`ADDR_W-1:0] sel_ir,
    input  cpu_stage_e         sel_stage,
    input  logic               bus_idle,
    output logic               grant,
    output logic               switching
);

    localparam int CNT_W = $clog2(`HOLD_CYCLES + 1);

    arb_state_e       state;
    logic [CNT_W-1:0] hold_cnt;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [11:0]      funct12;
    logic             is_alu;
    logic             is_wfi;
    logic             safe_point;

    // fields of the instruction on the granted core
    assign opcode  = sel_ir[6:0];
    assign funct3  = sel_ir[14:12];
    assign funct12 = sel_ir[31:20];

    assign is_alu = (opcode == `OPCODE_OP) || (opcode == `OPCODE_OP_IMM);
    assign is_wfi = (opcode == `OPCODE_SYSTEM) && (funct3 == `FUNCT3_PRIV)
                    && (funct12 == `FUNCT12_WFI);

    // alu op in decode needs no memory, wfi in finish has left the pipe
    assign safe_point = (is_alu && (sel_stage == S_ID))
                        || (is_wfi && (sel_stage == S_FIN));

    // both cores are held off while the grant moves
    assign switching = (state == CHECK) || (state == SWITCH);

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state    <= IDLE;
            grant    <= 1'b0;
            hold_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (safe_point && bus_idle) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    // a transfer may have opened on the edge into CHECK
                    if (safe_point && bus_idle) begin
                        // two cores, so the grant just toggles
                        grant <= ~grant;
                        state <= SWITCH;
                    end else begin
                        state <= IDLE;
                    end
                end
                SWITCH: begin
                    hold_cnt <= '0;
                    state    <= HOLD;
                end
                HOLD: begin
                    // HOLD_CYCLES+1 cycles for the new core
                    if (hold_cnt == CNT_W'(`HOLD_CYCLES)) begin
                        state <= IDLE;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // grant moves only when a check succeeds
    a_grant_on_switch: assert property (@(posedge CLK) disable iff (!RST_X)
        (grant != $past(grant)) |-> ((state == SWITCH) && ($past(state) == CHECK)));

    // the mux opened no transfer while the grant moved
    a_idle_at_switch: assert property (@(posedge CLK) disable iff (!RST_X)
        (state == SWITCH) |-> bus_idle);

endmodule

// ==== verilog/dual_core_bus_top.sv ====
`timescale 1ns/1ps
`include "dual_core_macros.svh"

module dual_core_bus_top
    import dual_core_pkg::*;
(
    input  logic               CLK,
    input  logic               RST_X,
    input  logic [`ADDR_W-1:0] ir0,
    input  cpu_stage_e         stage0,
    input  logic               req0,
    input  logic [`ADDR_W-1:0] addr0,
    input  logic               we0,
    input  logic [`DATA_W-1:0] wdata0,
    output logic [`DATA_W-1:0] rdata0,
    output logic               done0,
    output logic               busy0,
    input  logic [`ADDR_W-1:0] ir1,
    input  cpu_stage_e         stage1,
    input  logic               req1,
    input  logic [`ADDR_W-1:0] addr1,
    input  logic               we1,
    input  logic [`DATA_W-1:0] wdata1,
    output logic [`DATA_W-1:0] rdata1,
    output logic               done1,
    output logic               busy1,
    output logic               grant
);

    // granted core's status, seen by the arbiter
    logic [`ADDR_W-1:0] sel_ir;
    cpu_stage_e         sel_stage;
    logic               bus_idle;
    logic               switching;

    // APB between the mux and the memory
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`ADDR_W-1:0] paddr;
    logic [`DATA_W-1:0] pwdata;
    logic [`DATA_W-1:0] prdata;
    logic               pready;

    core_switch_arbiter i_arb (.*);

    core_bus_mux i_mux (.*);

    apb_shared_mem i_mem (.*);

endmodule

// ==== verilog/dual_core_macros.svh ====
`ifndef DUAL_CORE_MACROS_SVH
`define DUAL_CORE_MACROS_SVH

// system size
`define NCORES         2
`define ADDR_W         32
`define DATA_W         32

// cycles the new core keeps the bus after a switch
`define HOLD_CYCLES    10

// stand-in memory for DRAM
`define MEM_WORDS      256
// access cycles with PREADY low
`define MEM_WAIT       2

// RISC-V encodings used to find safe points
`define OPCODE_OP      7'b0110011
`define OPCODE_OP_IMM  7'b0010011
`define OPCODE_SYSTEM  7'b1110011
`define FUNCT3_PRIV    3'b000
`define FUNCT12_WFI    12'h105

`endif

// ==== verilog/dual_core_pkg.sv ====
package dual_core_pkg;

    // arbiter sequence around one core switch
    typedef enum logic [1:0] {
        // wait for a safe point on the granted core
        IDLE   = 2'd0,
        // safe point seen, confirm it one cycle later
        CHECK  = 2'd1,
        // grant has just flipped
        SWITCH = 2'd2,
        // new core keeps the bus for the hold window
        HOLD   = 2'd3
    } arb_state_e;

    // pipeline stage reported by each core
    typedef enum logic [3:0] {
        S_IF  = 4'd0,
        S_ID  = 4'd1,
        S_EX  = 4'd2,
        S_MA  = 4'd3,
        S_WB  = 4'd4,
        // instruction has retired
        S_FIN = 4'd5
    } cpu_stage_e;

endpackage
